//--- logic/alu_pipe.sv
// Single-cycle integer ALU pipe.
// Result is computed combinationally and registered together with its
// sequence number and destination, so the writeback follows accept by one cycle.

`timescale 1ns/1ps

module alu_pipe (
  input  logic               clk,
  input  logic               rst,

  input  logic               op_val,
  input  exec_pkg::pipe_op_t op,

  output logic               wb_val,
  output exec_pkg::wb_t      wb
);

  logic [exec_pkg::xlen-1:0] a;
  logic [exec_pkg::xlen-1:0] b;
  logic [4:0]                shamt;
  logic [exec_pkg::xlen-1:0] result;

  assign a     = op.op.a;
  assign b     = op.op.b;
  assign shamt = b[4:0]; // Low 5 bits only

  always_comb begin
    case (op.op.opcode)
      exec_pkg::op_add:  result = a + b;
      exec_pkg::op_sub:  result = a - b;
      exec_pkg::op_and:  result = a & b;
      exec_pkg::op_or:   result = a | b;
      exec_pkg::op_xor:  result = a ^ b;
      exec_pkg::op_slt:  result = {{(exec_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
      exec_pkg::op_sltu: result = {{(exec_pkg::xlen-1){1'b0}}, a < b};
      exec_pkg::op_sll:  result = a << shamt;
      exec_pkg::op_srl:  result = a >> shamt;
      exec_pkg::op_sra:  result = $signed(a) >>> shamt;
      default:           result = '0; // Multiply/divide never steered here
    endcase
  end

  // ------------------------------
  // Writeback register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_val <= 1'b0;
    end else begin
      wb_val <= op_val;
    end
  end

  always_ff @(posedge clk) begin
    if (op_val) begin
      wb.seq   <= op.seq;
      wb.waddr <= op.op.waddr;
      wb.wdata <= result;
    end
  end

endmodule

//--- logic/commit_unit.sv
// Reorder buffer and in-order commit.
// Writebacks from both pipes land in the slot given by their sequence
// number. The head slot is committed one per cycle once it is done.

`timescale 1ns/1ps

module commit_unit (
  input  logic                          clk,
  input  logic                          rst,

  input  logic                          alu_wb_val,
  input  exec_pkg::wb_t                 alu_wb,
  input  logic                          md_wb_val,
  input  exec_pkg::wb_t                 md_wb,

  output logic [exec_pkg::seq_bits-1:0] commit_head,
  output logic                          commit_val,
  output exec_pkg::commit_t             commit
);

  logic [exec_pkg::rob_depth-1:0]     done_q;
  logic [exec_pkg::reg_addr_bits-1:0] waddr_q [exec_pkg::rob_depth];
  logic [exec_pkg::xlen-1:0]          wdata_q [exec_pkg::rob_depth];
  logic [exec_pkg::seq_bits-1:0]      head_q;
  logic                               head_done;

  assign head_done   = done_q[head_q];
  assign commit_head = head_q;

  // ------------------------------
  // Done bits and head pointer
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      done_q     <= '0;
      head_q     <= '0;
      commit_val <= 1'b0;
    end else begin
      commit_val <= head_done;
      if (head_done) begin
        done_q[head_q] <= 1'b0; // Slot free again
        head_q         <= head_q + 1'b1;
      end
      if (alu_wb_val) begin
        done_q[alu_wb.seq] <= 1'b1;
      end
      if (md_wb_val) begin
        done_q[md_wb.seq] <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Entry storage
  // ------------------------------

  always_ff @(posedge clk) begin
    if (alu_wb_val) begin
      waddr_q[alu_wb.seq] <= alu_wb.waddr;
      wdata_q[alu_wb.seq] <= alu_wb.wdata;
    end
    if (md_wb_val) begin
      waddr_q[md_wb.seq] <= md_wb.waddr;
      wdata_q[md_wb.seq] <= md_wb.wdata;
    end
    if (head_done) begin
      commit.seq   <= head_q;
      commit.waddr <= waddr_q[head_q];
      commit.wdata <= wdata_q[head_q];
    end
  end

  // A slot is written back once per issue
  alu_wb_slot_free: assert property (
    @(posedge clk) disable iff (rst) alu_wb_val |-> !done_q[alu_wb.seq]
  );

  md_wb_slot_free: assert property (
    @(posedge clk) disable iff (rst) md_wb_val |-> !done_q[md_wb.seq]
  );

endmodule

//--- logic/exec_cluster.sv
// Execute cluster top level.
// Router feeds the ALU and multiply/divide pipes, the commit unit puts
// results back in program order, and the APB block gates issue.

`timescale 1ns/1ps

module exec_cluster (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               issue_val,
  input  exec_pkg::issue_op_t                issue_op,
  output logic                               issue_rdy,

  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [exec_pkg::apb_addr_bits-1:0] paddr,
  input  logic [exec_pkg::xlen-1:0]          pwdata,
  output logic [exec_pkg::xlen-1:0]          prdata,
  output logic                               pready,
  output logic                               pslverr,

  output logic                               commit_val,
  output exec_pkg::commit_t                  commit
);

  logic                          issue_en;
  logic                          md_busy;
  logic [exec_pkg::seq_bits-1:0] commit_head;
  logic                          alu_val;
  exec_pkg::pipe_op_t            alu_op;
  logic                          md_val;
  exec_pkg::pipe_op_t            md_op;
  logic                          alu_wb_val;
  exec_pkg::wb_t                 alu_wb;
  logic                          md_wb_val;
  exec_pkg::wb_t                 md_wb;

  // ------------------------------
  // Issue and execute
  // ------------------------------

  issue_router router_i (
    .clk, .rst,
    .issue_val, .issue_op, .issue_rdy,
    .issue_en, .md_busy, .commit_head,
    .alu_val, .alu_op,
    .md_val, .md_op
  );

  alu_pipe alu_i (
    .clk, .rst,
    .op_val (alu_val),
    .op     (alu_op),
    .wb_val (alu_wb_val),
    .wb     (alu_wb)
  );

  muldiv_pipe md_i (
    .clk, .rst,
    .op_val (md_val),
    .op     (md_op),
    .busy   (md_busy),
    .wb_val (md_wb_val),
    .wb     (md_wb)
  );

  // ------------------------------
  // Commit and registers
  // ------------------------------

  commit_unit commit_i (
    .clk, .rst,
    .alu_wb_val, .alu_wb,
    .md_wb_val, .md_wb,
    .commit_head,
    .commit_val, .commit
  );

  exec_csr_apb csr_i (
    .clk, .rst,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .commit_val,
    .issue_en
  );

endmodule

//--- logic/exec_csr_apb.sv
// APB register block of the execute cluster.
// CTRL bit 0 enables issue. COMMIT_CNT counts committed operations and
// is read only. Unmapped accesses and writes to COMMIT_CNT get pslverr.

`timescale 1ns/1ps

module exec_csr_apb (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [exec_pkg::apb_addr_bits-1:0] paddr,
  input  logic [exec_pkg::xlen-1:0]          pwdata,
  output logic [exec_pkg::xlen-1:0]          prdata,
  output logic                               pready,
  output logic                               pslverr,

  input  logic                               commit_val,
  output logic                               issue_en
);

  logic                      sel_ctrl;
  logic                      sel_cnt;
  logic                      bad_access;
  logic                      setup;
  logic                      access;
  logic [exec_pkg::xlen-1:0] commit_cnt_q;

  assign sel_ctrl   = (paddr == exec_pkg::reg_ctrl_addr);
  assign sel_cnt    = (paddr == exec_pkg::reg_commit_cnt_addr);
  assign bad_access = !(sel_ctrl || sel_cnt) || (pwrite && sel_cnt);

  assign setup  = psel && !penable;
  assign access = psel && penable;

  assign pready = 1'b1; // No wait states

  always_comb begin
    prdata = '0;
    if (sel_ctrl) begin
      prdata[0] = issue_en;
    end else if (sel_cnt) begin
      prdata = commit_cnt_q;
    end
  end

  // ------------------------------
  // Registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_en     <= 1'b0;
      commit_cnt_q <= '0;
      pslverr      <= 1'b0;
    end else begin
      pslverr <= setup && bad_access; // Valid in the access phase
      if (access && pwrite && sel_ctrl) begin
        issue_en <= pwdata[0];
      end
      if (commit_val) begin
        commit_cnt_q <= commit_cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- logic/exec_pkg.sv
// Shared definitions for the execute cluster.
// Widths, the opcode set, the packed payloads that travel between the
// router, the two pipes and the commit unit, and the pipe-class function.
// Referenced everywhere with exec_pkg:: scoped names.

package exec_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  localparam int xlen          = 32;
  localparam int seq_bits      = 3;
  localparam int rob_depth     = 2 ** seq_bits; // One slot per sequence number
  localparam int reg_addr_bits = 5;
  localparam int apb_addr_bits = 4;

  // Register map
  localparam logic [apb_addr_bits-1:0] reg_ctrl_addr       = 4'h0;
  localparam logic [apb_addr_bits-1:0] reg_commit_cnt_addr = 4'h4;

  // ------------------------------
  // Opcodes
  // ------------------------------

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_sltu,
    op_sll,
    op_srl,
    op_sra,
    op_mul,   // Low half of product
    op_mulhu, // High half, unsigned
    op_divu,
    op_remu
  } opcode_t;

  // ------------------------------
  // Payloads
  // ------------------------------

  typedef struct packed {
    opcode_t                  opcode;
    logic [xlen-1:0]          a;
    logic [xlen-1:0]          b;
    logic [reg_addr_bits-1:0] waddr;
  } issue_op_t;

  typedef struct packed {
    issue_op_t           op;
    logic [seq_bits-1:0] seq; // Program order tag
  } pipe_op_t;

  typedef struct packed {
    logic [seq_bits-1:0]      seq;
    logic [reg_addr_bits-1:0] waddr;
    logic [xlen-1:0]          wdata;
  } wb_t;

  typedef struct packed {
    logic [seq_bits-1:0]      seq;
    logic [reg_addr_bits-1:0] waddr;
    logic [xlen-1:0]          wdata;
  } commit_t;

  // Steering rule, multiply/divide pipe or ALU
  function automatic logic is_muldiv(opcode_t opc);
    return opc inside {op_mul, op_mulhu, op_divu, op_remu};
  endfunction

endpackage

//--- logic/issue_router.sv
// Issue router of the execute cluster.
// Tags each accepted operation with a sequence number, keeps the number
// of operations in flight, and steers to the ALU or multiply/divide pipe.

`timescale 1ns/1ps

module issue_router (
  input  logic                             clk,
  input  logic                             rst,

  input  logic                             issue_val,
  input  exec_pkg::issue_op_t              issue_op,
  output logic                             issue_rdy,

  input  logic                             issue_en,
  input  logic                             md_busy,
  input  logic [exec_pkg::seq_bits-1:0]    commit_head,

  output logic                             alu_val,
  output exec_pkg::pipe_op_t               alu_op,
  output logic                             md_val,
  output exec_pkg::pipe_op_t               md_op
);

  logic [exec_pkg::seq_bits-1:0] tail_q;
  logic [exec_pkg::seq_bits-1:0] head_seen_q; // Last commit_head observed
  logic [exec_pkg::seq_bits:0]   count_q;     // 0 .. rob_depth
  logic [exec_pkg::seq_bits:0]   count_nxt;
  logic                          to_md;
  logic                          accept;
  logic                          freed;
  exec_pkg::pipe_op_t            tagged_op;

  // ------------------------------
  // Handshake
  // ------------------------------

  assign to_md     = exec_pkg::is_muldiv(issue_op.opcode);
  assign issue_rdy = issue_en && (count_q != exec_pkg::rob_depth) && !(to_md && md_busy);
  assign accept    = issue_val && issue_rdy;

  assign tagged_op.op  = issue_op;
  assign tagged_op.seq = tail_q;

  assign alu_val = accept && !to_md;
  assign alu_op  = tagged_op;
  assign md_val  = accept && to_md;
  assign md_op   = tagged_op;

  // ------------------------------
  // Occupancy
  // ------------------------------

  // Head moves by one per commit at most
  assign freed = (commit_head != head_seen_q);

  always_comb begin
    count_nxt = count_q;
    if (accept && !freed) begin
      count_nxt = count_q + 1'b1;
    end else if (!accept && freed) begin
      count_nxt = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_q      <= '0;
      head_seen_q <= '0;
      count_q     <= '0;
    end else begin
      head_seen_q <= commit_head;
      count_q     <= count_nxt;
      if (accept) begin
        tail_q <= tail_q + 1'b1; // Wraps with the ROB
      end
    end
  end

  // Tail on the oldest live slot means the ROB is full, a new tag would alias
  no_accept_when_full: assert property (
    @(posedge clk) disable iff (rst)
    accept |-> (tail_q != head_seen_q) || (count_q == '0)
  );

endmodule

//--- logic/muldiv_pipe.sv
// Iterative multiply/divide pipe, one operation at a time.
// Shift-add multiply and restoring divide share the hi/lo register pair.
// One load cycle, 32 iteration cycles, then a writeback cycle.

`timescale 1ns/1ps

module muldiv_pipe (
  input  logic               clk,
  input  logic               rst,

  input  logic               op_val,
  input  exec_pkg::pipe_op_t op,
  output logic               busy,

  output logic               wb_val,
  output exec_pkg::wb_t      wb
);

  typedef enum logic [1:0] {
    idle,
    run,
    done
  } state_t;

  state_t                            state_q;
  logic [$clog2(exec_pkg::xlen)-1:0] iter_q;
  exec_pkg::pipe_op_t                op_q;      // Held for the whole operation
  logic [exec_pkg::xlen-1:0]         hi_q;      // Product high / remainder
  logic [exec_pkg::xlen-1:0]         lo_q;      // Product low / quotient
  logic                              ld_div;
  logic                              is_div;
  logic                              b_zero;
  logic [exec_pkg::xlen:0]           mul_sum;
  logic [exec_pkg::xlen:0]           div_shift;
  logic [exec_pkg::xlen:0]           div_diff;
  logic                              div_fits;
  logic [exec_pkg::xlen-1:0]         result;

  assign ld_div = op.op.opcode inside {exec_pkg::op_divu, exec_pkg::op_remu};
  assign is_div = op_q.op.opcode inside {exec_pkg::op_divu, exec_pkg::op_remu};
  assign b_zero = (op_q.op.b == '0);

  // ------------------------------
  // Iteration step
  // ------------------------------

  // Add multiplicand into upper half when the low bit is set
  assign mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, op_q.op.a} : '0);
  assign div_shift = {hi_q, lo_q[exec_pkg::xlen-1]};
  assign div_diff  = div_shift - {1'b0, op_q.op.b};
  assign div_fits  = (div_shift >= {1'b0, op_q.op.b});

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= idle;
      iter_q  <= '0;
    end else begin
      case (state_q)
        idle: begin
          iter_q <= '0;
          if (op_val) begin
            state_q <= run;
          end
        end
        run: begin
          iter_q <= iter_q + 1'b1;
          if (&iter_q) begin
            state_q <= done; // Last of 32 steps
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == idle && op_val) begin
      op_q <= op;
      hi_q <= '0;
      lo_q <= ld_div ? op.op.a : op.op.b; // Dividend or multiplier
    end else if (state_q == run) begin
      if (is_div) begin
        hi_q <= div_fits ? div_diff[exec_pkg::xlen-1:0] : div_shift[exec_pkg::xlen-1:0];
        lo_q <= {lo_q[exec_pkg::xlen-2:0], div_fits};
      end else begin
        hi_q <= mul_sum[exec_pkg::xlen:1];
        lo_q <= {mul_sum[0], lo_q[exec_pkg::xlen-1:1]};
      end
    end
  end

  // ------------------------------
  // Result select
  // ------------------------------

  // RISC-V divide-by-zero values
  always_comb begin
    case (op_q.op.opcode)
      exec_pkg::op_mul:   result = lo_q;
      exec_pkg::op_mulhu: result = hi_q;
      exec_pkg::op_divu:  result = b_zero ? '1 : lo_q;
      exec_pkg::op_remu:  result = b_zero ? op_q.op.a : hi_q;
      default:            result = '0;
    endcase
  end

  assign busy     = (state_q != idle);
  assign wb_val   = (state_q == done);
  assign wb.seq   = op_q.seq;
  assign wb.waddr = op_q.op.waddr;
  assign wb.wdata = result;

  // Router must hold multiply/divide issue while an operation runs
  no_issue_while_busy: assert property (
    @(posedge clk) disable iff (rst) busy |-> !op_val
  );

endmodule

//--- sources.f
logic/exec_pkg.sv
logic/issue_router.sv
logic/alu_pipe.sv
logic/muldiv_pipe.sv
logic/commit_unit.sv
logic/exec_csr_apb.sv
logic/exec_cluster.sv
tb/exec_cluster_tb.sv

//--- tb/exec_cluster_tb.sv
// Testbench for the execute cluster.
// Drives the issue port and APB, predicts every result with a reference
// function and checks each commit against the acceptance order.
// Compile with sources.f, top module exec_cluster_tb.

`timescale 1ns/1ps

module exec_cluster_tb;

  localparam int max_wait = 200; // Cycles allowed per wait loop

  logic                               clk;
  logic                               rst;
  logic                               issue_val;
  exec_pkg::issue_op_t                issue_op;
  logic                               issue_rdy;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [exec_pkg::apb_addr_bits-1:0] paddr;
  logic [exec_pkg::xlen-1:0]          pwdata;
  logic [exec_pkg::xlen-1:0]          prdata;
  logic                               pready;
  logic                               pslverr;
  logic                               commit_val;
  exec_pkg::commit_t                  commit;

  exec_pkg::commit_t             expect_q [$]; // Accepted, not yet committed
  logic [31:0]                   lfsr_state;
  logic [exec_pkg::seq_bits-1:0] next_seq;
  int                            accepted;
  int                            committed;
  int                            max_in_flight;

  exec_cluster exec_cluster_i (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run("A DUT output did not match its expected value");
    end
  endtask

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]}; // One step per bit
    end
    return r;
  endfunction

  // Expected result straight from the opcode rules
  function automatic logic [31:0] ref_result(input exec_pkg::opcode_t opc,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [63:0] wide;
    logic [4:0]  sh;
    sh   = b[4:0];
    wide = {32'b0, a} * {32'b0, b};
    case (opc)
      exec_pkg::op_add:   return a + b;
      exec_pkg::op_sub:   return a - b;
      exec_pkg::op_and:   return a & b;
      exec_pkg::op_or:    return a | b;
      exec_pkg::op_xor:   return a ^ b;
      exec_pkg::op_slt:   return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      exec_pkg::op_sltu:  return {31'b0, a < b};
      exec_pkg::op_sll:   return a << sh;
      exec_pkg::op_srl:   return a >> sh;
      exec_pkg::op_mul:   return wide[31:0];
      exec_pkg::op_mulhu: return wide[63:32];
      exec_pkg::op_divu:  return (b == 0) ? 32'hffff_ffff : a / b;
      exec_pkg::op_remu:  return (b == 0) ? a : a % b;
      default: begin
        wide = {{32{a[31]}}, a} >> sh; // Arithmetic shift via sign extension
        return wide[31:0];
      end
    endcase
  endfunction

  // ------------------------------
  // Issue and APB drivers
  // ------------------------------

  task automatic issue_one(input exec_pkg::opcode_t opc, input logic [31:0] a,
                           input logic [31:0] b, input logic [4:0] waddr);
    exec_pkg::commit_t exp_c;
    int                waited;
    waited          = 0;
    issue_val       = 1'b1;
    issue_op.opcode = opc;
    issue_op.a      = a;
    issue_op.b      = b;
    issue_op.waddr  = waddr;
    @(negedge clk);
    while (!issue_rdy) begin
      waited++;
      if (waited > max_wait) abort_run("Timed out waiting for issue_rdy");
      @(negedge clk);
    end
    // Accepted on the coming edge
    exp_c.seq   = next_seq;
    exp_c.waddr = waddr;
    exp_c.wdata = ref_result(opc, a, b);
    expect_q.push_back(exp_c);
    next_seq++;
    accepted++;
    if (accepted - committed > max_in_flight) max_in_flight = accepted - committed;
    assert (accepted - committed <= exec_pkg::rob_depth) else
      abort_run($sformatf("%0d operations in flight, more than the reorder depth",
                          accepted - committed));
    @(posedge clk);
    #1;
    issue_val = 1'b0;
  endtask

  task automatic apb_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    waited  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1; // Access phase
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited > max_wait) abort_run("Timed out waiting for pready");
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, data, unused, err);
    check_eq("pslverr", err, exp_err);
  endtask

  task automatic apb_read(input logic [3:0] addr, input logic exp_err, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'h0, data, err);
    check_eq("pslverr", err, exp_err);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (expect_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > max_wait) abort_run("Timed out waiting for outstanding commits");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic expect_rdy_low(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_eq("issue_rdy", issue_rdy, 1'b0);
    end
    @(posedge clk);
    #1;
  endtask

  // Operation waits while issue is off, then goes in once CTRL is set
  task automatic enable_and_issue(input exec_pkg::opcode_t opc, input logic [31:0] a,
                                  input logic [31:0] b);
    fork
      issue_one(opc, a, b, 5'd3);
      begin
        expect_rdy_low(6);
        apb_write(exec_pkg::reg_ctrl_addr, 32'h1, 1'b0);
      end
    join
  endtask

  // ------------------------------
  // Commit checker
  // ------------------------------

  always @(negedge clk) begin : commit_check
    exec_pkg::commit_t exp_c;
    if (!rst && commit_val) begin
      if (expect_q.size() == 0) begin
        abort_run("Commit seen with no operation outstanding");
      end else begin
        exp_c = expect_q.pop_front();
        check_eq("commit.seq", commit.seq, exp_c.seq);
        check_eq("commit.waddr", commit.waddr, exp_c.waddr);
        check_eq("commit.wdata", commit.wdata, exp_c.wdata);
        committed++;
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin
    exec_pkg::opcode_t opc;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [4:0]        wa;
    logic [31:0]       rd;
    rst           = 1'b1;
    issue_val     = 1'b0;
    issue_op      = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    lfsr_state    = 32'hf23d_1f25;
    next_seq      = '0;
    accepted      = 0;
    committed     = 0;
    max_in_flight = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    check_eq("issue_rdy", issue_rdy, 1'b0);
    check_eq("commit_val", commit_val, 1'b0);
    check_eq("pslverr", pslverr, 1'b0);
    @(posedge clk);
    #1;

    // Issue gating, on then off again
    enable_and_issue(exec_pkg::op_add, 32'h1234_5678, 32'h0000_1111);
    wait_drained();
    apb_write(exec_pkg::reg_ctrl_addr, 32'h0, 1'b0);
    enable_and_issue(exec_pkg::op_xor, 32'hdead_beef, 32'hffff_0000);
    wait_drained();

    // Random ALU traffic
    for (int i = 0; i < 60; i++) begin
      opc = exec_pkg::opcode_t'(4'(i % 10)); // Every ALU opcode in turn
      a   = rand_bits(32);
      b   = rand_bits(32);
      wa  = rand_bits(5);
      issue_one(opc, a, b, wa);
    end
    issue_one(exec_pkg::op_sra, 32'h8000_0010, 32'hffff_ffe4, 5'd7); // Shift by 4
    issue_one(exec_pkg::op_slt, 32'hffff_fff0, 32'h0000_0001, 5'd8);
    wait_drained();

    // Multiply/divide, directed corners then random
    issue_one(exec_pkg::op_mul, 32'hffff_ffff, 32'hffff_ffff, 5'd9);
    issue_one(exec_pkg::op_mulhu, 32'hffff_ffff, 32'hffff_ffff, 5'd10);
    issue_one(exec_pkg::op_divu, 32'h0000_1234, 32'h0000_0000, 5'd11);
    issue_one(exec_pkg::op_remu, 32'h0000_1234, 32'h0000_0000, 5'd12);
    issue_one(exec_pkg::op_divu, 32'h0000_0005, 32'h0000_0064, 5'd13);
    issue_one(exec_pkg::op_remu, 32'h0000_0005, 32'h0000_0064, 5'd14);
    for (int i = 0; i < 8; i++) begin
      opc = exec_pkg::opcode_t'(4'(10 + rand_bits(2)));
      a   = rand_bits(32);
      b   = rand_bits(32);
      issue_one(opc, a, b, 5'd15);
    end
    wait_drained();

    // Long divide ahead of short ALU ops, commit stays in order
    issue_one(exec_pkg::op_divu, 32'h7654_3210, 32'h0000_0123, 5'd16);
    for (int i = 0; i < 5; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      issue_one(exec_pkg::op_sub, a, b, 5'(17 + i));
    end
    wait_drained();

    // Fill the reorder buffer behind a multiply
    max_in_flight = 0;
    issue_one(exec_pkg::op_mul, 32'h0001_0003, 32'h0002_0005, 5'd24);
    for (int i = 0; i < 12; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      issue_one(exec_pkg::op_or, a, b, 5'd25);
    end
    wait_drained();
    check_eq("max in flight", max_in_flight, exec_pkg::rob_depth);

    // Register reads and bad accesses
    apb_read(exec_pkg::reg_commit_cnt_addr, 1'b0, rd);
    check_eq("COMMIT_CNT", rd, committed);
    apb_read(exec_pkg::reg_ctrl_addr, 1'b0, rd);
    check_eq("CTRL", rd, 32'h1);
    apb_write(exec_pkg::reg_commit_cnt_addr, 32'h55, 1'b1);
    apb_read(4'h8, 1'b1, rd);
    apb_write(4'h8, 32'h1, 1'b1);
    apb_read(exec_pkg::reg_commit_cnt_addr, 1'b0, rd);
    check_eq("COMMIT_CNT", rd, committed); // Unchanged by the refused write

    $display("Test passed");
    $finish;
  end

endmodule
